/* Makefile */
VERILATOR ?= verilator
TOP       ?= ingress_port_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* design/async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo
    import frame_pkg::*;
#(
    parameter int DEPTH = 512
)
(
    input  wire        rst_n,
    input  wire        wr_clk,
    input  wire        wr_en,
    input  wire word_t wr_data,
    output logic       full,
    input  wire        rd_clk,
    input  wire        rd_en,
    output word_t      rd_data,
    output logic       empty
);

    localparam int AW = $clog2(DEPTH);

    typedef logic [AW:0] ptr_t;   // one extra bit tells a wrap from a match

    word_t mem [DEPTH];

    ptr_t wr_bin, wr_gray, wr_bin_next, wr_gray_next;
    ptr_t rd_bin, rd_gray, rd_bin_next, rd_gray_next;
    ptr_t rd_gray_s1, rd_gray_s2;   // read pointer as seen by the write side
    ptr_t wr_gray_s1, wr_gray_s2;

    // ######################################################################
    // write domain
    // ######################################################################

    assign wr_bin_next  = wr_bin + ptr_t'(wr_en && !full);
    assign wr_gray_next = (wr_bin_next >> 1) ^ wr_bin_next;

    always_ff @(posedge wr_clk) begin
        if (wr_en && !full) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (!rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            full       <= 1'b0;
        end else begin
            wr_bin     <= wr_bin_next;
            wr_gray    <= wr_gray_next;
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            // full when the write pointer has lapped the read pointer once
            full <= (wr_gray_next == {~rd_gray_s2[AW:AW-1], rd_gray_s2[AW-2:0]});
        end
    end

    // ######################################################################
    // read domain
    // ######################################################################

    assign rd_bin_next  = rd_bin + ptr_t'(rd_en && !empty);
    assign rd_gray_next = (rd_bin_next >> 1) ^ rd_bin_next;

    always_ff @(posedge rd_clk) begin
        if (!rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            empty      <= 1'b1;
        end else begin
            rd_bin     <= rd_bin_next;
            rd_gray    <= rd_gray_next;
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            empty      <= (rd_gray_next == wr_gray_s2);
        end
    end

    assign rd_data = mem[rd_bin[AW-1:0]];   // the head word is valid while not empty

endmodule

`default_nettype wire

/* design/crc16_word.sv */
`timescale 1ns/1ps
`default_nettype none

module crc16_word
    import port_cfg_pkg::*;
    import frame_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        clear,
    input  wire        crc_en,
    input  wire word_t data_in,
    output crc_t       crc_out
);

    crc_t crc_q;

    // CCITT polynomial 0x1021 folded in one bit per step with the word's msb first
    function automatic crc_t crc_fold(input crc_t crc_in, input word_t data);
        crc_t c;
        c = crc_in;
        for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
            if (c[15] ^ data[i]) begin
                c = {c[14:0], 1'b0} ^ 16'h1021;
            end else begin
                c = {c[14:0], 1'b0};
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            crc_q <= 16'hFFFF;   // clear wins over a data word
        end else if (crc_en) begin
            crc_q <= crc_fold(crc_q, data_in);
        end
    end

    assign crc_out = crc_q;

endmodule

`default_nettype wire

/* design/desc_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_sync
    import frame_pkg::*;
(
    input  wire              rst_n,
    input  wire              external_clk,
    input  wire              internal_clk,
    input  wire frame_desc_t desc,
    input  wire              desc_valid,
    output logic             desc_done,
    output frame_desc_t      rd_desc,
    output logic             rd_desc_valid,
    input  wire              rd_desc_ack
);

    frame_desc_t data_q;   // stable for as long as the request is pending
    logic        req_tog;
    logic        ack_s1, ack_s2;
    logic        req_s1, req_s2;
    logic        ack_tog;
    logic        busy;
    logic        start;

    // ######################################################################
    // external clock side
    // ######################################################################

    assign busy  = req_tog ^ ack_s2;
    assign start = desc_valid && !busy && !desc_done;

    always_ff @(posedge external_clk) begin
        if (start) data_q <= desc;
    end

    always_ff @(posedge external_clk) begin
        if (!rst_n) begin
            req_tog   <= 1'b0;
            ack_s1    <= 1'b0;
            ack_s2    <= 1'b0;
            desc_done <= 1'b0;
        end else begin
            ack_s1    <= ack_tog;
            ack_s2    <= ack_s1;
            desc_done <= start;   // writer may move on once the copy is taken
            if (start) req_tog <= ~req_tog;
        end
    end

    // ######################################################################
    // internal clock side
    // ######################################################################

    always_ff @(posedge internal_clk) begin
        if (!rst_n) begin
            req_s1  <= 1'b0;
            req_s2  <= 1'b0;
            ack_tog <= 1'b0;
        end else begin
            req_s1 <= req_tog;
            req_s2 <= req_s1;
            if (rd_desc_ack) ack_tog <= ~ack_tog;
        end
    end

    assign rd_desc_valid = req_s2 ^ ack_tog;   // request level differs from ack level
    assign rd_desc       = data_q;

endmodule

`default_nettype wire

/* design/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    import port_cfg_pkg::*;

    typedef logic [WORD_WIDTH-1:0]           word_t;
    typedef logic [$clog2(PORT_TOTAL)-1:0]   port_sel_t;
    typedef logic [$clog2(PRIO_LEVELS)-1:0]  prio_t;
    typedef logic [$clog2(LENGTH_MAX+1)-1:0] frame_len_t;
    typedef logic [15:0]                     crc_t;

    // everything the read side needs to know about one stored frame
    typedef struct packed {
        logic       error;
        port_sel_t  dest;
        prio_t      prio;
        frame_len_t length;   // as announced by the header
        frame_len_t stored;   // words that actually went into the FIFO
        crc_t       crc;
    } frame_desc_t;

    typedef enum logic [1:0] {
        HEADER,
        PAYLOAD,
        FLUSH,
        HANDOFF
    } wr_state_t;

    typedef enum logic [2:0] {
        IDLE,
        CTRL,
        DATA,
        DRAIN,
        ACK
    } rd_state_t;

endpackage

`default_nettype wire

/* design/ingress_port.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_port
    import frame_pkg::*;
#(
    parameter int FIFO_DEPTH = 512,
    parameter int PORT_ID    = 0
)
(
    input  wire        external_clk,
    input  wire        internal_clk,
    input  wire        rst_n,
    input  wire        wr_sop,
    input  wire        wr_eop,
    input  wire        wr_vld,
    input  wire word_t wr_data,
    output logic       wr_ready,
    input  wire        out_ready,
    output logic       out_vld,
    output logic       out_sop,
    output word_t      out_data,
    output port_sel_t  out_dest
);

    logic        fifo_wr_en, fifo_full;
    logic        fifo_rd_en, fifo_empty;
    word_t       fifo_rd_data;
    logic        crc_clear;
    crc_t        crc_value;
    frame_desc_t desc, rd_desc;
    logic        desc_valid, desc_done;
    logic        rd_desc_valid, rd_desc_ack;

    // only words that go into the FIFO count toward the CRC
    crc16_word i_crc (
        .clk(external_clk), .rst_n(rst_n), .clear(crc_clear),
        .crc_en(fifo_wr_en), .data_in(wr_data), .crc_out(crc_value)
    );

    async_fifo #(.DEPTH(FIFO_DEPTH)) i_fifo (
        .rst_n(rst_n), .wr_clk(external_clk), .wr_en(fifo_wr_en), .wr_data(wr_data),
        .full(fifo_full), .rd_clk(internal_clk), .rd_en(fifo_rd_en),
        .rd_data(fifo_rd_data), .empty(fifo_empty)
    );

    ingress_wr_ctrl i_wr_ctrl (
        .external_clk(external_clk), .rst_n(rst_n), .wr_sop(wr_sop), .wr_eop(wr_eop),
        .wr_vld(wr_vld), .wr_data(wr_data), .wr_ready(wr_ready), .fifo_full(fifo_full),
        .fifo_wr_en(fifo_wr_en), .crc_clear(crc_clear), .crc_value(crc_value),
        .desc(desc), .desc_valid(desc_valid), .desc_done(desc_done)
    );

    desc_sync i_desc_sync (
        .rst_n(rst_n), .external_clk(external_clk), .internal_clk(internal_clk),
        .desc(desc), .desc_valid(desc_valid), .desc_done(desc_done), .rd_desc(rd_desc),
        .rd_desc_valid(rd_desc_valid), .rd_desc_ack(rd_desc_ack)
    );

    ingress_rd_ctrl #(.PORT_ID(PORT_ID)) i_rd_ctrl (
        .internal_clk(internal_clk), .rst_n(rst_n), .rd_desc(rd_desc),
        .rd_desc_valid(rd_desc_valid), .rd_desc_ack(rd_desc_ack),
        .fifo_rd_data(fifo_rd_data), .fifo_empty(fifo_empty), .fifo_rd_en(fifo_rd_en),
        .out_ready(out_ready), .out_vld(out_vld), .out_sop(out_sop),
        .out_data(out_data), .out_dest(out_dest)
    );

endmodule

`default_nettype wire

/* design/ingress_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_rd_ctrl
    import frame_pkg::*;
#(
    parameter int PORT_ID = 0
)
(
    input  wire              internal_clk,
    input  wire              rst_n,
    input  wire frame_desc_t rd_desc,
    input  wire              rd_desc_valid,
    output logic             rd_desc_ack,
    input  wire word_t       fifo_rd_data,
    input  wire              fifo_empty,
    output logic             fifo_rd_en,
    input  wire              out_ready,
    output logic             out_vld,
    output logic             out_sop,
    output word_t            out_data,
    output port_sel_t        out_dest
);

    rd_state_t   state;
    frame_desc_t cur;
    frame_len_t  count;      // words popped for the current frame
    logic        out_free;   // output register can take a new word this cycle
    logic        pop;
    logic        take;

    assign out_free    = !out_vld || out_ready;
    assign take        = (state == IDLE) && rd_desc_valid;
    assign rd_desc_ack = (state == ACK);
    assign fifo_rd_en  = pop;

    always_comb begin
        pop = 1'b0;
        if (!fifo_empty) begin
            if (state == DATA) pop = out_free && (count != cur.length);
            if (state == DRAIN) pop = (count != cur.stored);
        end
    end

    always_ff @(posedge internal_clk) begin
        if (take) cur <= rd_desc;
        if (take && !rd_desc.error) begin
            out_data <= {port_sel_t'(PORT_ID), rd_desc.prio, rd_desc.length, rd_desc.crc};
            out_dest <= rd_desc.dest;
        end else if (pop && state == DATA) begin
            out_data <= fifo_rd_data;
        end
    end

    always_ff @(posedge internal_clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            out_vld <= 1'b0;
            out_sop <= 1'b0;
            count   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        count <= '0;
                        if (rd_desc.error) begin
                            state <= DRAIN;   // bad frames never reach the output
                        end else begin
                            out_vld <= 1'b1;
                            out_sop <= 1'b1;
                            state   <= CTRL;
                        end
                    end
                end
                CTRL: begin
                    if (out_ready) begin
                        out_vld <= 1'b0;
                        out_sop <= 1'b0;
                        state   <= DATA;
                    end
                end
                DATA: begin
                    if (out_free) begin
                        out_vld <= pop;
                        if (pop) count <= count + 1'b1;
                        else if (count == cur.length) state <= ACK;
                    end
                end
                DRAIN: begin
                    if (count == cur.stored) state <= ACK;
                    else if (pop) count <= count + 1'b1;
                end
                ACK: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/ingress_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_wr_ctrl
    import frame_pkg::*;
(
    input  wire        external_clk,
    input  wire        rst_n,
    input  wire        wr_sop,
    input  wire        wr_eop,
    input  wire        wr_vld,
    input  wire word_t wr_data,
    output logic       wr_ready,
    input  wire        fifo_full,
    output logic       fifo_wr_en,
    output logic       crc_clear,
    input  wire crc_t  crc_value,
    output frame_desc_t desc,
    output logic       desc_valid,
    input  wire        desc_done
);

    wr_state_t  state;
    logic       ready_q;   // stays low until the first clock out of reset
    logic       accept;
    logic       room;      // header still expects more payload
    logic       err;
    port_sel_t  hdr_dest;
    prio_t      hdr_prio;
    frame_len_t hdr_len;
    frame_len_t stored;

    assign wr_ready   = ready_q && (state != HANDOFF) && !fifo_full;
    assign accept     = wr_vld && wr_ready;
    assign room       = (stored < hdr_len);
    assign fifo_wr_en = accept && (state == PAYLOAD) && !wr_sop && room;
    assign crc_clear  = accept && (state == HEADER) && wr_sop;
    assign desc_valid = (state == HANDOFF);

    always_ff @(posedge external_clk) begin
        if (crc_clear) begin
            hdr_dest <= wr_data[15:12];
            hdr_prio <= wr_data[11:9];
            hdr_len  <= wr_data[8:0];
        end
    end

    always_ff @(posedge external_clk) begin
        if (!rst_n) begin
            state   <= HEADER;
            ready_q <= 1'b0;
            err     <= 1'b0;
            stored  <= '0;
        end else begin
            ready_q <= 1'b1;
            case (state)
                HEADER: begin
                    if (crc_clear) begin   // words outside a frame are dropped
                        stored <= '0;
                        err    <= (wr_data[8:0] == '0) || wr_eop;
                        state  <= wr_eop ? HANDOFF : PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (fifo_wr_en) begin
                        stored <= stored + 1'b1;
                        if (wr_eop) begin
                            err   <= err || (frame_len_t'(stored + 1'b1) != hdr_len);
                            state <= HANDOFF;
                        end
                    end else if (accept) begin
                        err   <= 1'b1;   // sop inside a frame, or one word too many
                        state <= wr_eop ? HANDOFF : FLUSH;
                    end
                end
                FLUSH: begin
                    if (accept && wr_eop) state <= HANDOFF;
                end
                HANDOFF: begin
                    if (desc_done) state <= HEADER;
                end
                default: state <= HEADER;
            endcase
        end
    end

    // crc_value is final here since nothing is written during HANDOFF
    always_comb begin
        desc.error  = err;
        desc.dest   = hdr_dest;
        desc.prio   = hdr_prio;
        desc.length = hdr_len;
        desc.stored = stored;
        desc.crc    = crc_value;
    end

endmodule

`default_nettype wire

/* design/port_cfg_pkg.sv */
`default_nettype none

// ##########################################################################
// switch port constants
// ##########################################################################

package port_cfg_pkg;

    // bus word width in bits
    localparam int WORD_WIDTH = 32;

    localparam int PORT_TOTAL = 16;   // ports on the switch fabric

    // longest payload a header can announce, in words
    localparam int LENGTH_MAX = 511;

    localparam int PRIO_LEVELS = 8;

endpackage

`default_nettype wire

/* sources.f */
design/port_cfg_pkg.sv
design/frame_pkg.sv
design/crc16_word.sv
design/async_fifo.sv
design/ingress_wr_ctrl.sv
design/desc_sync.sv
design/ingress_rd_ctrl.sv
design/ingress_port.sv
verif/tb_clock_gen.sv
verif/ingress_port_assertions.sv
verif/ingress_port_tb.sv

/* verif/ingress_port_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_port_assertions
    import frame_pkg::*;
(
    input wire       external_clk,
    input wire       internal_clk,
    input wire       rst_n,
    input wire       wr_ready,
    input wire       out_ready,
    input wire       out_vld,
    input wire       out_sop,
    input wire word_t     out_data,
    input wire port_sel_t out_dest
);

    // a stalled output word must not move
    assert property (@(posedge internal_clk) disable iff (!rst_n)
        out_vld && !out_ready |=> $stable(out_vld) && $stable(out_sop)
                                  && $stable(out_data) && $stable(out_dest))
        else $error("output changed while stalled");

    assert property (@(posedge internal_clk) disable iff (!rst_n) out_sop |-> out_vld)
        else $error("out_sop high without out_vld");

    assert property (@(posedge external_clk) !rst_n |=> !wr_ready)
        else $error("wr_ready high during reset");   // ready register needs one edge

endmodule

bind ingress_port ingress_port_assertions i_assertions (
    .external_clk(external_clk), .internal_clk(internal_clk), .rst_n(rst_n),
    .wr_ready(wr_ready), .out_ready(out_ready), .out_vld(out_vld),
    .out_sop(out_sop), .out_data(out_data), .out_dest(out_dest)
);

`default_nettype wire

/* verif/ingress_port_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_port_tb
    import port_cfg_pkg::*;
    import frame_pkg::*;
();

    localparam int GOOD = 0, SHORT = 1, LONG = 2, SOP_IN = 3, ZERO = 4;
    localparam int FRAME_TOTAL = 37;
    localparam int TIMEOUT_CYCLES = FRAME_TOTAL * (LENGTH_MAX + 20) * 4;
    localparam int STALL_WAIT_CYCLES = (LENGTH_MAX + 20) * 4;

    typedef struct packed {
        logic      sop;
        port_sel_t dest;
        word_t     data;
    } out_beat_t;

    logic      external_clk, internal_clk;
    logic      rst_n = 1'b0;
    logic      wr_sop = 1'b0, wr_eop = 1'b0, wr_vld = 1'b0;
    word_t     wr_data = '0;
    logic      out_ready = 1'b0;
    wire       wr_ready, out_vld, out_sop;
    word_t     out_data;
    port_sel_t out_dest;

    out_beat_t   exp_q[$];
    int unsigned stim_seed  = 37542;
    int unsigned ready_seed = 37542 ^ 32'h5a5a;
    int          ready_mode = 2;   // 0 high, 1 random, 2 low
    int          error_count = 0, check_count = 0, tests_run = 0, errors_before = 0;
    int          cycle_count = 0;
    logic        saw_stall = 1'b0;

    tb_clock_gen #(.PERIOD_NS(100.0), .PHASE_NS(0.0))  i_ext_clk (.clk(external_clk));
    tb_clock_gen #(.PERIOD_NS(100.0), .PHASE_NS(37.0)) i_int_clk (.clk(internal_clk));

    ingress_port #(.FIFO_DEPTH(512), .PORT_ID(5)) i_dut (
        .external_clk(external_clk), .internal_clk(internal_clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .wr_ready(wr_ready), .out_ready(out_ready), .out_vld(out_vld),
        .out_sop(out_sop), .out_data(out_data), .out_dest(out_dest)
    );

    function automatic int unsigned lcg_next(inout int unsigned state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state >> 8;   // low bits of an LCG are weak
    endfunction

    // byte-wise CCITT with the msb of each byte first
    function automatic crc_t crc_model(input word_t words[$]);
        logic [15:0] crc;
        crc = 16'hFFFF;
        foreach (words[i]) begin
            for (int b = 3; b >= 0; b--) begin
                crc = crc ^ {words[i][b*8 +: 8], 8'h00};
                for (int k = 0; k < 8; k++) begin
                    crc = crc[15] ? ((crc << 1) ^ 16'h1021) : (crc << 1);
                end
            end
        end
        return crc;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_word(input logic sop, input logic eop, input word_t data);
        wr_sop  = sop;
        wr_eop  = eop;
        wr_data = data;
        wr_vld  = 1'b1;
        while (!wr_ready) @(negedge external_clk);
        @(negedge external_clk);
    endtask

    task automatic send_frame(input int kind, input int len);
        port_sel_t dest;
        prio_t     prio;
        word_t     hdr;
        word_t     payload[$];
        int        n_words;
        out_beat_t beat;
        dest = port_sel_t'(lcg_next(stim_seed));
        prio = prio_t'(lcg_next(stim_seed));
        hdr  = {16'(lcg_next(stim_seed)), dest, prio, frame_len_t'(len)};
        case (kind)
            SHORT:   n_words = len - 1;
            LONG:    n_words = len + 2;
            ZERO:    n_words = 2;
            default: n_words = len;
        endcase
        for (int i = 0; i < n_words; i++) payload.push_back(word_t'(lcg_next(stim_seed) ^
                                                             (lcg_next(stim_seed) << 16)));
        if (kind == GOOD) begin
            beat = '{sop: 1'b1, dest: dest,
                     data: {4'd5, prio, frame_len_t'(len), crc_model(payload)}};
            exp_q.push_back(beat);
            foreach (payload[i]) exp_q.push_back('{sop: 1'b0, dest: dest, data: payload[i]});
        end
        send_word(1'b1, 1'b0, hdr);
        foreach (payload[i]) begin
            send_word(kind == SOP_IN && i == 1, i == n_words - 1, payload[i]);
        end
        wr_vld = 1'b0;
        wr_sop = 1'b0;
        wr_eop = 1'b0;
        repeat (lcg_next(stim_seed) % 4) @(negedge external_clk);
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(posedge internal_clk);
        repeat (40) @(posedge internal_clk);   // room for any stray word to show up
        @(negedge external_clk);
    endtask

    task automatic test_done(input string name);
        tests_run++;
        $display("test %s finished with %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    always @(negedge internal_clk) begin
        case (ready_mode)
            0:       out_ready <= 1'b1;
            1:       out_ready <= (lcg_next(ready_seed) % 4) != 0;
            default: out_ready <= 1'b0;
        endcase
    end

    always @(posedge internal_clk) begin
        out_beat_t beat;
        if (rst_n && out_vld && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output word 0x%0h appeared when no frame was expected", out_data);
                error_count++;
            end else begin
                beat = exp_q.pop_front();
                check_value("out_sop", out_sop, beat.sop);
                check_value("out_data", out_data, beat.data);
                check_value("out_dest", out_dest, beat.dest);
            end
        end
    end

    always @(posedge external_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ######################################################################
    // test sequence
    // ######################################################################

    initial begin
        repeat (16) @(negedge external_clk);
        rst_n = 1'b1;

        // quiet output after reset
        repeat (20) begin
            @(posedge internal_clk);
            check_value("out_vld", out_vld, 1'b0);
            check_value("out_sop", out_sop, 1'b0);
        end
        test_done("reset_idle");

        ready_mode = 0;
        @(negedge external_clk);
        repeat (6) send_frame(GOOD, 1 + lcg_next(stim_seed) % 16);
        wait_drained();
        test_done("good_frames");

        for (int k = SHORT; k <= ZERO; k++) begin
            send_frame(k, (k == ZERO) ? 0 : 2 + lcg_next(stim_seed) % 15);
            send_frame(GOOD, 1 + lcg_next(stim_seed) % 16);
        end
        wait_drained();
        test_done("error_frames");

        ready_mode = 1;
        repeat (20) send_frame(lcg_next(stim_seed) % 4, 2 + lcg_next(stim_seed) % 15);
        wait_drained();
        test_done("random_ready");

        ready_mode = 2;
        fork
            repeat (3) send_frame(GOOD, LENGTH_MAX);
            begin
                int low_run;
                int waited;
                low_run = 0;
                waited  = 0;
                while (low_run < 64 && waited < STALL_WAIT_CYCLES) begin
                    @(negedge external_clk);
                    waited++;
                    low_run = wr_ready ? 0 : low_run + 1;
                end
                saw_stall = (low_run >= 64);
                ready_mode = 0;
            end
        join
        wait_drained();
        if (!saw_stall) begin
            $display("wr_ready never fell while the output was blocked");
            error_count++;
        end
        test_done("back_pressure");

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter realtime PERIOD_NS = 100.0,
    parameter realtime PHASE_NS  = 0.0
)
(
    output logic clk
);

    initial begin
        clk = 1'b0;
        #(PHASE_NS);
        forever #(PERIOD_NS / 2.0) clk = ~clk;   // 50 percent duty cycle
    end

endmodule

`default_nettype wire
